/* list.f */
stq_cfg_pkg.sv
stq_types_pkg.sv
stq_addr_entry.sv
stq_addr_array.sv
stq_alloc.sv
stq_fwd_select.sv
stq_top.sv
stq_asserts.sv
stq_tb.sv

/* Bender.yml */
package:
  name: stq_addr

sources:
  - files:
      - stq_cfg_pkg.sv
      - stq_types_pkg.sv
      - stq_addr_entry.sv
      - stq_addr_array.sv
      - stq_alloc.sv
      - stq_fwd_select.sv
      - stq_top.sv
  - target: test
    files:
      - stq_asserts.sv
      - stq_tb.sv

/* stq_tb.sv */
module stq_tb
  import stq_cfg_pkg::*, stq_types_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MAX_CYCLES = 400;

  logic clk = 1'b0;
  logic rst;
  logic alloc0_en, alloc1_en, upd_en, commit_en, retire_en, excpt, chk0_en, chk1_en;
  addr_t alloc0_addr_e, alloc0_addr_o, alloc1_addr_e, alloc1_addr_o;
  addr_t chk0_addr_e, chk0_addr_o, chk1_addr_e, chk1_addr_o;
  idx_t upd_idx;
  idx_t alloc0_idx, alloc1_idx, chk0_idx, chk1_idx;
  cnt_t count;
  logic full, chk0_valid, chk1_valid;
  bank_hit_t chk0_hit, chk1_hit;

  // Reference model of the queue
  addr_t m_ae [STQ_DEPTH];
  addr_t m_ao [STQ_DEPTH];
  mask_t m_free = '1;
  mask_t m_upd = '1;
  mask_t m_passe = '0;
  idx_t m_tail = '0;
  idx_t m_cmt = '0;
  idx_t m_head = '0;
  cnt_t m_count = '0;

  logic [31:0] lfsr = 32'he973;
  string test_name = "reset";
  int cycles = 0;
  addr_t shared;

  stq_top stq_top_i (.*);

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) stop_with_error("Run did not finish within the cycle limit");
  end

  task automatic stop_with_error(string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_hit(string what, bank_hit_t exp, bank_hit_t act);
    if (act !== exp)
      stop_with_error($sformatf("FAIL %s %s expected %b actual %b", test_name, what, exp, act));
  endtask

  task automatic check_idx(string what, idx_t exp, idx_t act);
    if (act !== exp)
      stop_with_error($sformatf("FAIL %s %s expected %0d actual %0d", test_name, what, exp, act));
  endtask

  task automatic check_count(cnt_t exp, cnt_t act);
    if (act !== exp)
      stop_with_error($sformatf("FAIL %s count expected %0d actual %0d", test_name, exp, act));
  endtask

  task automatic check_flag(string what, logic exp, logic act);
    if (act !== exp)
      stop_with_error($sformatf("FAIL %s %s expected %b actual %b", test_name, what, exp, act));
  endtask

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic addr_t rand_addr();
    addr_t a;
    for (int b = 0; b < ADDR_W; b++) begin
      lfsr = lfsr_step(lfsr);
      a[b] = lfsr[0];
    end
    return a;
  endfunction

  function automatic bank_hit_t exp_hit(addr_t e, addr_t o);
    bank_hit_t h;
    h = '0;
    for (int i = 0; i < STQ_DEPTH; i++)
      if (!m_free[i] && !m_passe[i]) h = h | {m_ao[i] == o, m_ae[i] == e};
    return h;
  endfunction

  // Walk back from the newest store
  function automatic idx_t exp_idx(addr_t e, addr_t o);
    idx_t pos;
    for (int k = 1; k <= STQ_DEPTH; k++) begin
      pos = m_tail - idx_t'(k);
      if (!m_free[pos] && !m_passe[pos] && (m_ae[pos] == e || m_ao[pos] == o)) return pos;
    end
    return '0;
  endfunction

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic write_entry(idx_t i, addr_t e, addr_t o);
    m_ae[i] = e;
    m_ao[i] = o;
    m_free[i] = 1'b0;
    m_upd[i] = 1'b0;
    m_passe[i] = 1'b0;
  endtask

  task automatic do_alloc(logic dual, addr_t e0, addr_t o0, addr_t e1, addr_t o1);
    logic ok;
    ok = dual ? (cnt_t'(STQ_DEPTH) - m_count >= 2) : (m_count < cnt_t'(STQ_DEPTH));
    check_idx("alloc0_idx", m_tail, alloc0_idx);
    check_idx("alloc1_idx", m_tail + idx_t'(1), alloc1_idx);
    alloc0_en = 1'b1;
    alloc1_en = dual;
    {alloc0_addr_e, alloc0_addr_o, alloc1_addr_e, alloc1_addr_o} = {e0, o0, e1, o1};
    tick();
    alloc0_en = 1'b0;
    alloc1_en = 1'b0;
    if (ok) begin
      write_entry(m_tail, e0, o0);
      if (dual) write_entry(m_tail + idx_t'(1), e1, o1);
      m_tail = m_tail + idx_t'(dual ? 2 : 1);
      m_count = m_count + cnt_t'(dual ? 2 : 1);
    end
    check_count(m_count, count);
    check_flag("full", (cnt_t'(STQ_DEPTH) - m_count) < 2, full);
  endtask

  task automatic do_update(idx_t i);
    upd_en = 1'b1;
    upd_idx = i;
    tick();
    upd_en = 1'b0;
    m_upd[i] = 1'b1;
  endtask

  task automatic do_commit();
    logic ok;
    ok = !m_free[m_cmt] && m_upd[m_cmt] && !m_passe[m_cmt];
    commit_en = 1'b1;
    tick();
    commit_en = 1'b0;
    if (ok) begin
      m_passe[m_cmt] = 1'b1;
      m_cmt = m_cmt + idx_t'(1);
    end
  endtask

  task automatic do_retire();
    if (m_passe[m_head]) begin
      m_free[m_head] = 1'b1;
      m_passe[m_head] = 1'b0;
      m_head = m_head + idx_t'(1);
      m_count = m_count - cnt_t'(1);
    end
    retire_en = 1'b1;
    tick();
    retire_en = 1'b0;
    check_count(m_count, count);
  endtask

  // Drop every store not yet committed
  task automatic do_flush();
    for (int i = 0; i < STQ_DEPTH; i++)
      if (!m_free[i] && !m_passe[i]) begin
        m_free[i] = 1'b1;
        m_count = m_count - cnt_t'(1);
      end
    m_tail = m_cmt;
    excpt = 1'b1;
    tick();
    excpt = 1'b0;
    check_count(m_count, count);
  endtask

  task automatic check_ports(addr_t e0, addr_t o0, addr_t e1, addr_t o1);
    bank_hit_t h0, h1;
    idx_t i0, i1;
    h0 = exp_hit(e0, o0);
    h1 = exp_hit(e1, o1);
    i0 = exp_idx(e0, o0);
    i1 = exp_idx(e1, o1);
    {chk0_en, chk1_en} = 2'b11;
    {chk0_addr_e, chk0_addr_o, chk1_addr_e, chk1_addr_o} = {e0, o0, e1, o1};
    tick();
    {chk0_en, chk1_en} = 2'b00;
    if (chk0_valid !== 1'b1 || chk1_valid !== 1'b1)
      stop_with_error($sformatf("In test %s a check result did not come back one cycle later",
                                test_name));
    check_hit("chk0_hit", h0, chk0_hit);
    check_idx("chk0_idx", i0, chk0_idx);
    check_hit("chk1_hit", h1, chk1_hit);
    check_idx("chk1_idx", i1, chk1_idx);
  endtask

  task automatic test_alloc();
    test_name = "alloc";
    do_alloc(1'b0, rand_addr(), rand_addr(), '0, '0);
    for (int n = 0; n < 3; n++)
      do_alloc(1'b1, rand_addr(), rand_addr(), rand_addr(), rand_addr());
    check_flag("full", 1'b1, full);  // 7 stores
    do_alloc(1'b1, rand_addr(), rand_addr(), rand_addr(), rand_addr());
    check_count(cnt_t'(7), count);
    do_flush();
    check_count(cnt_t'(0), count);
  endtask

  task automatic test_match();
    test_name = "match";
    do_alloc(1'b1, rand_addr(), rand_addr(), rand_addr(), rand_addr());
    do_alloc(1'b1, rand_addr(), rand_addr(), rand_addr(), rand_addr());
    for (int i = 0; i < 4; i++)
      check_ports(m_ae[i], rand_addr(), rand_addr(), m_ao[i]);
    check_ports(m_ae[1], m_ao[3], m_ae[2], m_ao[0]);  // Both banks hit
    check_ports(rand_addr(), rand_addr(), rand_addr(), rand_addr());
    check_hit("miss", 2'b00, chk0_hit);
    check_idx("miss", idx_t'(0), chk0_idx);
  endtask

  task automatic test_commit_retire();
    test_name = "commit";
    do_commit();  // Entry 0 still waits for its update
    check_ports(m_ae[0], rand_addr(), rand_addr(), rand_addr());
    check_hit("pending", 2'b01, chk0_hit);
    do_update(0);
    do_commit();
    check_ports(m_ae[0], m_ao[0], rand_addr(), rand_addr());
    check_hit("committed", 2'b00, chk0_hit);
    do_retire();
    for (int i = 1; i < 4; i++) begin
      do_update(idx_t'(i));
      do_commit();
      do_retire();
    end
    check_count(cnt_t'(0), count);
  endtask

  task automatic test_youngest();
    test_name = "youngest";
    shared = rand_addr();
    do_alloc(1'b1, rand_addr(), rand_addr(), shared, rand_addr());  // Entries 4 and 5
    check_ports(shared, rand_addr(), shared, rand_addr());
    do_alloc(1'b1, rand_addr(), rand_addr(), shared, rand_addr());
    check_ports(shared, rand_addr(), shared, rand_addr());
    do_alloc(1'b1, shared, rand_addr(), rand_addr(), rand_addr());  // Tail wraps to 0
    check_ports(shared, rand_addr(), shared, rand_addr());
    check_idx("wrapped", idx_t'(0), chk1_idx);
  endtask

  task automatic test_flush();
    test_name = "flush";
    do_update(4);
    do_commit();
    do_update(5);
    do_commit();
    do_flush();
    check_count(cnt_t'(2), count);
    check_ports(shared, rand_addr(), m_ae[6], m_ao[1]);
    check_hit("flushed", 2'b00, chk0_hit);
    check_idx("next alloc", idx_t'(6), alloc0_idx);
    do_alloc(1'b0, rand_addr(), rand_addr(), '0, '0);
    do_retire();
    do_retire();
    check_count(cnt_t'(1), count);
  endtask

  initial begin
    rst = 1'b1;
    {alloc0_en, alloc1_en, upd_en, commit_en, retire_en, excpt, chk0_en, chk1_en} = '0;
    {alloc0_addr_e, alloc0_addr_o, alloc1_addr_e, alloc1_addr_o} = '0;
    {chk0_addr_e, chk0_addr_o, chk1_addr_e, chk1_addr_o} = '0;
    upd_idx = '0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    test_alloc();
    test_match();
    test_commit_retire();
    test_youngest();
    test_flush();
    if (stq_top_i.u_alloc.u_asserts.fail_cnt != 0) begin
      stop_with_error("Allocator assertions failed during the run");
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

/* stq_asserts.sv */
module stq_alloc_asserts
  import stq_cfg_pkg::*, stq_types_pkg::*;
(
  input logic clk,
  input logic rst,
  input logic excpt,
  input mask_t free,
  input mask_t passe,
  input mask_t wrt0_mask,
  input mask_t wrt1_mask,
  input cnt_t count,
  input logic full
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_cnt = 0;  // Failed assertions so far

  count_in_range: assert property (@(posedge clk) disable iff (rst)
      count <= cnt_t'(STQ_DEPTH))
    else begin
      fail_cnt++;
      $error("Store queue count above its depth");
    end

  // Full as soon as fewer than two entries are left
  full_matches_count: assert property (@(posedge clk) disable iff (rst)
      full == ($countones(free) < 2))
    else begin
      fail_cnt++;
      $error("Full flag does not follow the free entries");
    end

  write_to_free_only: assert property (@(posedge clk) disable iff (rst)
      ((wrt0_mask | wrt1_mask) & ~free) == '0)
    else begin
      fail_cnt++;
      $error("Allocation writes an entry that is in use");
    end

  // Outside a flush only committed entries may be freed
  retire_passed_only: assert property (@(posedge clk) disable iff (rst)
      !excpt |=> (free & ~$past(free) & ~$past(passe)) == '0)
    else begin
      fail_cnt++;
      $error("Retire frees an entry that was never committed");
    end

endmodule

bind stq_alloc stq_alloc_asserts u_asserts (
  .clk(clk), .rst(rst), .excpt(excpt),
  .free(free), .passe(passe),
  .wrt0_mask(wrt0_mask), .wrt1_mask(wrt1_mask),
  .count(count), .full(full)
);

/* stq_top.sv */
module stq_top
  import stq_cfg_pkg::*, stq_types_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic alloc0_en,
  input  addr_t alloc0_addr_e,
  input  addr_t alloc0_addr_o,
  input  logic alloc1_en,
  input  addr_t alloc1_addr_e,
  input  addr_t alloc1_addr_o,
  input  logic upd_en,
  input  idx_t upd_idx,
  input  logic commit_en,
  input  logic retire_en,
  input  logic excpt,
  input  logic chk0_en,
  input  addr_t chk0_addr_e,
  input  addr_t chk0_addr_o,
  input  logic chk1_en,
  input  addr_t chk1_addr_e,
  input  addr_t chk1_addr_o,
  output idx_t alloc0_idx,
  output idx_t alloc1_idx,
  output cnt_t count,
  output logic full,
  output logic chk0_valid,
  output bank_hit_t chk0_hit,
  output idx_t chk0_idx,
  output logic chk1_valid,
  output bank_hit_t chk1_hit,
  output idx_t chk1_idx
);

  mask_t wrt0_mask, wrt1_mask, upd_mask, passe_mask, free_mask;
  mask_t free, upd, passe;
  idx_t tail;
  addr_t [CHK_PORTS-1:0] chk_addr_e;
  addr_t [CHK_PORTS-1:0] chk_addr_o;
  hit_vec_t [CHK_PORTS-1:0] chk_hits;
  logic [CHK_PORTS-1:0] chk_en;
  logic [CHK_PORTS-1:0] chk_valid;
  bank_hit_t [CHK_PORTS-1:0] chk_hit;
  idx_t [CHK_PORTS-1:0] chk_idx;

  // Check ports gathered into arrays, port 0 in the low slot
  assign chk_en     = {chk1_en, chk0_en};
  assign chk_addr_e = {chk1_addr_e, chk0_addr_e};
  assign chk_addr_o = {chk1_addr_o, chk0_addr_o};

  stq_alloc u_alloc (
    .clk(clk), .rst(rst),
    .alloc0_en(alloc0_en), .alloc1_en(alloc1_en),
    .upd_en(upd_en), .upd_idx(upd_idx),
    .commit_en(commit_en), .retire_en(retire_en), .excpt(excpt),
    .free(free), .upd(upd), .passe(passe),
    .wrt0_mask(wrt0_mask), .wrt1_mask(wrt1_mask), .upd_mask(upd_mask),
    .passe_mask(passe_mask), .free_mask(free_mask),
    .alloc0_idx(alloc0_idx), .alloc1_idx(alloc1_idx),
    .tail(tail), .count(count), .full(full)
  );

  stq_addr_array u_array (
    .clk(clk), .rst(rst),
    .wrt0_mask(wrt0_mask), .wrt1_mask(wrt1_mask), .upd_mask(upd_mask),
    .passe_mask(passe_mask), .free_mask(free_mask),
    .wrt0_addr_e(alloc0_addr_e), .wrt0_addr_o(alloc0_addr_o),
    .wrt1_addr_e(alloc1_addr_e), .wrt1_addr_o(alloc1_addr_o),
    .chk_addr_e(chk_addr_e), .chk_addr_o(chk_addr_o),
    .chk_hits(chk_hits),
    .free(free), .upd(upd), .passe(passe)
  );

  stq_fwd_select u_select (
    .clk(clk), .rst(rst),
    .chk_en(chk_en), .tail(tail), .chk_hits(chk_hits),
    .chk_valid(chk_valid), .chk_hit(chk_hit), .chk_idx(chk_idx)
  );

  assign chk0_valid = chk_valid[0];
  assign chk0_hit   = chk_hit[0];
  assign chk0_idx   = chk_idx[0];
  assign chk1_valid = chk_valid[1];
  assign chk1_hit   = chk_hit[1];
  assign chk1_idx   = chk_idx[1];

endmodule

/* stq_fwd_select.sv */
module stq_fwd_select
  import stq_cfg_pkg::*, stq_types_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic [CHK_PORTS-1:0] chk_en,
  input  idx_t tail,
  input  hit_vec_t [CHK_PORTS-1:0] chk_hits,
  output logic [CHK_PORTS-1:0] chk_valid,
  output bank_hit_t [CHK_PORTS-1:0] chk_hit,
  output idx_t [CHK_PORTS-1:0] chk_idx
);

  bank_hit_t [CHK_PORTS-1:0] hit_nxt;
  idx_t [CHK_PORTS-1:0] idx_nxt;

  // OR of bank bits, then youngest entry walking back from tail-1
  always_comb begin
    idx_t pos;
    hit_nxt = '0;
    idx_nxt = '0;
    pos = '0;
    for (int p = 0; p < CHK_PORTS; p++) begin
      for (int i = 0; i < STQ_DEPTH; i++)
        hit_nxt[p] = hit_nxt[p] | chk_hits[p][i];
      // Oldest candidate first so the nearest to tail-1 overwrites
      for (int k = STQ_DEPTH; k >= 1; k--) begin
        pos = tail - idx_t'(k);
        if (|chk_hits[p][pos]) idx_nxt[p] = pos;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      chk_valid <= '0;
    end else begin
      chk_valid <= chk_en;
    end
  end

  always_ff @(posedge clk) begin
    for (int p = 0; p < CHK_PORTS; p++) begin
      if (chk_en[p]) begin
        chk_hit[p] <= hit_nxt[p];
        chk_idx[p] <= idx_nxt[p];  // Stays 0 without a hit
      end
    end
  end

endmodule

/* stq_alloc.sv */
module stq_alloc
  import stq_cfg_pkg::*, stq_types_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic alloc0_en,
  input  logic alloc1_en,
  input  logic upd_en,
  input  idx_t upd_idx,
  input  logic commit_en,
  input  logic retire_en,
  input  logic excpt,
  input  mask_t free,
  input  mask_t upd,
  input  mask_t passe,
  output mask_t wrt0_mask,
  output mask_t wrt1_mask,
  output mask_t upd_mask,
  output mask_t passe_mask,
  output mask_t free_mask,
  output idx_t alloc0_idx,
  output idx_t alloc1_idx,
  output idx_t tail,
  output cnt_t count,
  output logic full
);

  idx_t cmt_ptr;
  idx_t head;
  logic alloc_ok;
  logic dual_ok;
  logic commit_ok;
  logic retire_ok;
  mask_t flush_mask;
  cnt_t n_alloc;
  cnt_t n_flush;

  // Flush has priority, second slot only together with the first
  assign alloc_ok = alloc0_en && !excpt &&
                    (alloc1_en ? (count <= cnt_t'(STQ_DEPTH - 2)) : (count < cnt_t'(STQ_DEPTH)));
  assign dual_ok  = alloc_ok && alloc1_en;
  assign n_alloc  = alloc_ok ? (dual_ok ? cnt_t'(2) : cnt_t'(1)) : '0;

  assign commit_ok = commit_en && !excpt && !free[cmt_ptr] && upd[cmt_ptr] && !passe[cmt_ptr];
  assign retire_ok = retire_en && passe[head];

  assign flush_mask = excpt ? (~free & ~passe) : '0;  // Everything not yet committed
  assign n_flush    = cnt_t'($countones(flush_mask));

  assign alloc0_idx = tail;
  assign alloc1_idx = tail + idx_t'(1);

  assign wrt0_mask  = alloc_ok ? (mask_t'(1) << alloc0_idx) : '0;
  assign wrt1_mask  = dual_ok ? (mask_t'(1) << alloc1_idx) : '0;
  assign upd_mask   = upd_en ? (mask_t'(1) << upd_idx) : '0;
  assign passe_mask = commit_ok ? (mask_t'(1) << cmt_ptr) : '0;
  assign free_mask  = flush_mask | (retire_ok ? (mask_t'(1) << head) : '0);

  assign full = count > cnt_t'(STQ_DEPTH - 2);

  always_ff @(posedge clk) begin
    if (rst) begin
      tail    <= '0;
      cmt_ptr <= '0;
      head    <= '0;
      count   <= '0;
    end else begin
      if (excpt) tail <= cmt_ptr;  // Restart behind the last committed store
      else tail <= tail + idx_t'(n_alloc);
      if (commit_ok) cmt_ptr <= cmt_ptr + idx_t'(1);
      if (retire_ok) head <= head + idx_t'(1);
      count <= count + n_alloc - n_flush - cnt_t'(retire_ok);
    end
  end

endmodule

/* stq_addr_array.sv */
module stq_addr_array
  import stq_cfg_pkg::*, stq_types_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  mask_t wrt0_mask,
  input  mask_t wrt1_mask,
  input  mask_t upd_mask,
  input  mask_t passe_mask,
  input  mask_t free_mask,
  input  addr_t wrt0_addr_e,
  input  addr_t wrt0_addr_o,
  input  addr_t wrt1_addr_e,
  input  addr_t wrt1_addr_o,
  input  addr_t [CHK_PORTS-1:0] chk_addr_e,
  input  addr_t [CHK_PORTS-1:0] chk_addr_o,
  output hit_vec_t [CHK_PORTS-1:0] chk_hits,
  output mask_t free,
  output mask_t upd,
  output mask_t passe
);

  // Match pairs as each entry produces them
  bank_hit_t [CHK_PORTS-1:0] ent_match [STQ_DEPTH];

  for (genvar i = 0; i < STQ_DEPTH; i++) begin : g_ent
    stq_addr_entry u_entry (
      .clk(clk), .rst(rst),
      .wrt0_en(wrt0_mask[i]), .wrt0_addr_e(wrt0_addr_e), .wrt0_addr_o(wrt0_addr_o),
      .wrt1_en(wrt1_mask[i]), .wrt1_addr_e(wrt1_addr_e), .wrt1_addr_o(wrt1_addr_o),
      .upd_en(upd_mask[i]),
      .passe_en(passe_mask[i]),
      .free_en(free_mask[i]),
      .chk_addr_e(chk_addr_e),
      .chk_addr_o(chk_addr_o),
      .chk_match(ent_match[i]),
      .free(free[i]), .upd(upd[i]), .passe(passe[i])
    );
  end

  // Entry-major to port-major
  always_comb begin
    for (int p = 0; p < CHK_PORTS; p++)
      for (int i = 0; i < STQ_DEPTH; i++)
        chk_hits[p][i] = ent_match[i][p];
  end

endmodule

/* stq_addr_entry.sv */
module stq_addr_entry
  import stq_cfg_pkg::*, stq_types_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic wrt0_en,
  input  addr_t wrt0_addr_e,
  input  addr_t wrt0_addr_o,
  input  logic wrt1_en,
  input  addr_t wrt1_addr_e,
  input  addr_t wrt1_addr_o,
  input  logic upd_en,
  input  logic passe_en,
  input  logic free_en,
  input  addr_t [CHK_PORTS-1:0] chk_addr_e,
  input  addr_t [CHK_PORTS-1:0] chk_addr_o,
  output bank_hit_t [CHK_PORTS-1:0] chk_match,
  output logic free,
  output logic upd,
  output logic passe
);

  addr_t addr_e;
  addr_t addr_o;
  logic live;

  always_ff @(posedge clk) begin
    if (wrt1_en) begin  // Second slot of a pair wins
      addr_e <= wrt1_addr_e;
      addr_o <= wrt1_addr_o;
    end else if (wrt0_en) begin
      addr_e <= wrt0_addr_e;
      addr_o <= wrt0_addr_o;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      free  <= 1'b1;
      upd   <= 1'b1;
      passe <= 1'b0;
    end else begin
      if (wrt0_en || wrt1_en) begin
        free  <= 1'b0;
        upd   <= 1'b0;  // Address update still pending
        passe <= 1'b0;
      end
      if (upd_en) upd <= 1'b1;
      if (passe_en) passe <= 1'b1;
      if (free_en) begin
        free  <= 1'b1;
        passe <= 1'b0;
      end
    end
  end

  // Committed or empty entries never forward
  assign live = ~free & ~passe;

  always_comb begin
    for (int p = 0; p < CHK_PORTS; p++) begin
      chk_match[p][0] = live && (chk_addr_e[p] == addr_e);
      chk_match[p][1] = live && (chk_addr_o[p] == addr_o);
    end
  end

endmodule

/* stq_types_pkg.sv */
package stq_types_pkg;

  import stq_cfg_pkg::*;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [IDX_W-1:0] idx_t;
  typedef logic [IDX_W:0] cnt_t;         // Holds 0 up to STQ_DEPTH
  typedef logic [STQ_DEPTH-1:0] mask_t;  // One bit per entry

  // Bit 0 even bank, bit 1 odd bank
  typedef logic [1:0] bank_hit_t;

  // Match pairs of all entries for one check port
  typedef bank_hit_t [STQ_DEPTH-1:0] hit_vec_t;

endpackage

/* stq_cfg_pkg.sv */
package stq_cfg_pkg;

  // Queue geometry
  localparam int STQ_DEPTH = 8;
  localparam int IDX_W = 3;     // log2 of STQ_DEPTH

  // One bank address, even or odd
  localparam int ADDR_W = 36;

  // Load check ports looking into the queue
  localparam int CHK_PORTS = 2;

endpackage
